/* logic/spi_flash_pkg.sv */
package spi_flash_pkg;

  localparam int FLASH_ADDR_W = 32;
  localparam int CACHE_ADDR_W = 24;
  localparam int DATA_W = 32;

  typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;
  typedef logic [CACHE_ADDR_W-1:0] cache_addr_t;
  typedef logic [DATA_W-1:0] flash_data_t;
  typedef logic [31:0] cmd_word_t;
  typedef logic [7:0] opcode_t;
  typedef logic [5:0] nbits_t;
  typedef logic [3:0] dummy_t;

  // command word fields.
  localparam int OPCODE_LSB = 0;
  localparam int OPCODE_MSB = 7;
  localparam int NDATA_LSB = 8;
  localparam int NDATA_MSB = 14;
  localparam int DUMMY_LSB = 16;
  localparam int DUMMY_MSB = 19;

  localparam int MAX_DATA_BITS = 32;
  localparam int OPCODE_BITS = 8;
  localparam int ADDR3_BITS = 24;
  localparam int ADDR4_BITS = 32;

  // one serial bit is two half periods of this many clocks.
  localparam int CLKS_PER_HALF_SCLK = 2;
  localparam int SCLK_CNT_W = $clog2(CLKS_PER_HALF_SCLK) + 1;

  typedef enum logic [2:0] {
    CT_CMD         = 3'd0,
    CT_ADDR        = 3'd1,
    CT_READ        = 3'd2,
    CT_WRITE       = 3'd3,
    CT_READ_NOADDR = 3'd4
  } comm_type_e;

  typedef enum logic [2:0] {
    ST_IDLE, ST_OPCODE, ST_ADDR, ST_DUMMY, ST_DATA, ST_END
  } ctrl_state_e;

endpackage

/* logic/spi_xfer_if.sv */
`timescale 1ns/1ps

interface spi_xfer_if;

  logic run;
  logic shift_stb;
  logic sample_stb;
  logic load;
  spi_flash_pkg::flash_data_t load_word;
  spi_flash_pkg::nbits_t load_len;
  // low on a load means a read phase follows.
  logic shift_out;
  spi_flash_pkg::flash_data_t rx_word;

  modport ctrl (
    output run, load, load_word, load_len, shift_out,
    input shift_stb, sample_stb
  );

  modport clkgen (input run, output shift_stb, sample_stb);

  modport shifter (
    input shift_stb, sample_stb, load, load_word, load_len, shift_out,
    output rx_word
  );

endinterface

/* logic/flash_req_mux.sv */
`timescale 1ns/1ps

module flash_req_mux (
  input  logic                      clk_i,
  input  logic                      arst_i,
  input  logic                      soft_rst,
  output logic                      core_rst,
  input  logic                      cache_valid,
  input  spi_flash_pkg::cache_addr_t cache_addr,
  input  logic [3:0]                cache_wstrb,
  output logic                      cache_ready,
  input  logic                      reg_valid,
  input  spi_flash_pkg::flash_addr_t reg_address,
  output logic                      start,
  output spi_flash_pkg::flash_addr_t sel_address,
  input  logic                      busy,
  input  logic                      done
);

  logic cache_req;
  logic cache_pend;

  assign core_rst = arst_i | soft_rst;

  // writes from the cache side are not served.
  assign cache_req = cache_valid & ~|cache_wstrb;

  assign sel_address = cache_req ? spi_flash_pkg::flash_addr_t'(cache_addr) : reg_address;

  assign start = (cache_req | reg_valid) & ~busy;

  // remembers that the running transfer belongs to the cache.
  always_ff @(posedge clk_i or posedge core_rst) begin
    if (core_rst) begin
      cache_pend <= 1'b0;
    end else if (start && cache_req) begin
      cache_pend <= 1'b1;
    end else if (done) begin
      cache_pend <= 1'b0;
    end
  end

  assign cache_ready = cache_pend & done;

  // a cache acknowledge only ends a cache transfer that the controller ran.
  a_cache_ready_pending: assert property (
    @(posedge clk_i) disable iff (core_rst)
    $rose(cache_ready) |-> $past(cache_pend)
  ) else $error("cache_ready rose without a pending cache transfer.");

endmodule

/* logic/sclk_gen.sv */
`timescale 1ns/1ps

module sclk_gen (
  input  logic              clk_i,
  input  logic              arst_i,
  spi_xfer_if.clkgen        xfer,
  output logic              sclk
);

  localparam logic [spi_flash_pkg::SCLK_CNT_W-1:0] HALF_LAST =
    spi_flash_pkg::SCLK_CNT_W'(spi_flash_pkg::CLKS_PER_HALF_SCLK - 1);

  logic [spi_flash_pkg::SCLK_CNT_W-1:0] half_cnt;
  logic shift_stb_q;
  logic sample_stb_q;

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      half_cnt     <= '0;
      sclk         <= 1'b0;
      shift_stb_q  <= 1'b0;
      sample_stb_q <= 1'b0;
    end else if (!xfer.run) begin
      half_cnt     <= '0;
      sclk         <= 1'b0;
      shift_stb_q  <= 1'b0;
      sample_stb_q <= 1'b0;
    end else if (half_cnt == HALF_LAST) begin
      // strobes line up with the new sclk level.
      half_cnt     <= '0;
      sclk         <= ~sclk;
      sample_stb_q <= ~sclk;
      shift_stb_q  <= sclk;
    end else begin
      half_cnt     <= half_cnt + 1'b1;
      shift_stb_q  <= 1'b0;
      sample_stb_q <= 1'b0;
    end
  end

  assign xfer.shift_stb  = shift_stb_q;
  assign xfer.sample_stb = sample_stb_q;

  // the controller may only stop the frame on a falling edge.
  a_sclk_idle_low: assert property (
    @(posedge clk_i) disable iff (arst_i)
    !xfer.run |-> !sclk
  ) else $error("sclk high while run is low.");

endmodule

/* logic/spi_shifter.sv */
`timescale 1ns/1ps

module spi_shifter (
  input  logic        clk_i,
  input  logic        arst_i,
  spi_xfer_if.shifter xfer,
  output logic        mosi,
  input  logic        miso
);

  spi_flash_pkg::flash_data_t tx_q;
  spi_flash_pkg::flash_data_t rx_q;
  spi_flash_pkg::nbits_t align_sh;

  // left-align so that the first bit of the word sits at the top.
  assign align_sh = spi_flash_pkg::nbits_t'(spi_flash_pkg::MAX_DATA_BITS) - xfer.load_len;

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      tx_q <= '0;
    end else if (xfer.load) begin
      if (xfer.shift_out) begin
        tx_q <= xfer.load_word << align_sh;
      end else begin
        tx_q <= '0;
      end
    end else if (xfer.shift_stb) begin
      tx_q <= {tx_q[spi_flash_pkg::DATA_W-2:0], 1'b0};
    end
  end

  assign mosi = tx_q[spi_flash_pkg::DATA_W-1];

  // read data fills from the right.
  always_ff @(posedge clk_i) begin
    if (xfer.load && !xfer.shift_out) begin
      rx_q <= '0;
    end else if (xfer.sample_stb) begin
      rx_q <= {rx_q[spi_flash_pkg::DATA_W-2:0], miso};
    end
  end

  assign xfer.rx_word = rx_q;

endmodule

/* logic/spi_flash_ctrl.sv */
`timescale 1ns/1ps

module spi_flash_ctrl (
  input  logic                      clk_i,
  input  logic                      arst_i,
  input  logic                      start,
  input  spi_flash_pkg::flash_addr_t address,
  input  spi_flash_pkg::cmd_word_t  command,
  input  spi_flash_pkg::comm_type_e comm_type,
  input  logic                      four_byte_addr,
  input  spi_flash_pkg::flash_data_t wdata,
  spi_xfer_if.ctrl                  xfer,
  output logic                      ss,
  output logic                      busy,
  output logic                      done
);

  localparam int NDATA_W = spi_flash_pkg::NDATA_MSB - spi_flash_pkg::NDATA_LSB + 1;

  spi_flash_pkg::ctrl_state_e state;
  spi_flash_pkg::ctrl_state_e nxt_phase;
  spi_flash_pkg::ctrl_state_e from_dummy;
  spi_flash_pkg::ctrl_state_e from_addr;

  spi_flash_pkg::opcode_t cmd_opcode;
  logic [NDATA_W-1:0] cmd_ndata;
  spi_flash_pkg::nbits_t cmd_nbits;

  spi_flash_pkg::flash_addr_t addr_q;
  spi_flash_pkg::flash_data_t wdata_q;
  spi_flash_pkg::nbits_t nbits_q;
  spi_flash_pkg::dummy_t dummy_q;
  spi_flash_pkg::comm_type_e type_q;
  logic four_q;

  spi_flash_pkg::nbits_t bit_cnt;
  spi_flash_pkg::nbits_t phase_len;
  logic run;
  logic bits_done;
  logic phase_adv;

  assign cmd_opcode = command[spi_flash_pkg::OPCODE_MSB:spi_flash_pkg::OPCODE_LSB];
  assign cmd_ndata  = command[spi_flash_pkg::NDATA_MSB:spi_flash_pkg::NDATA_LSB];

  // more than a word of data is cut to one word.
  assign cmd_nbits = (cmd_ndata > NDATA_W'(spi_flash_pkg::MAX_DATA_BITS)) ?
                     spi_flash_pkg::nbits_t'(spi_flash_pkg::MAX_DATA_BITS) :
                     spi_flash_pkg::nbits_t'(cmd_ndata);

  assign run       = (state != spi_flash_pkg::ST_IDLE) && (state != spi_flash_pkg::ST_END);
  assign bits_done = (bit_cnt == phase_len);
  assign phase_adv = run && bits_done && xfer.shift_stb;
  assign busy      = (state != spi_flash_pkg::ST_IDLE);
  assign done      = (state == spi_flash_pkg::ST_END);
  assign xfer.run  = run;

  // phase that follows the current one, skipping empty phases.
  always_comb begin
    from_dummy = (nbits_q != '0) ? spi_flash_pkg::ST_DATA : spi_flash_pkg::ST_END;
    from_addr  = spi_flash_pkg::ST_END;
    if (type_q == spi_flash_pkg::CT_READ) begin
      from_addr = (dummy_q != '0) ? spi_flash_pkg::ST_DUMMY : from_dummy;
    end else if (type_q == spi_flash_pkg::CT_WRITE) begin
      from_addr = from_dummy;
    end
    case (state)
      spi_flash_pkg::ST_OPCODE: begin
        if (type_q == spi_flash_pkg::CT_READ_NOADDR) begin
          nxt_phase = (dummy_q != '0) ? spi_flash_pkg::ST_DUMMY : from_dummy;
        end else if (type_q == spi_flash_pkg::CT_CMD) begin
          nxt_phase = spi_flash_pkg::ST_END;
        end else begin
          nxt_phase = spi_flash_pkg::ST_ADDR;
        end
      end
      spi_flash_pkg::ST_ADDR:  nxt_phase = from_addr;
      spi_flash_pkg::ST_DUMMY: nxt_phase = from_dummy;
      default:                 nxt_phase = spi_flash_pkg::ST_END;
    endcase
  end

  assign xfer.load = ((state == spi_flash_pkg::ST_IDLE) && start) ||
                     (phase_adv && (nxt_phase != spi_flash_pkg::ST_END));

  // word and length for the shifter at each phase start.
  always_comb begin
    xfer.load_word = '0;
    xfer.load_len  = '0;
    xfer.shift_out = 1'b1;
    if (state == spi_flash_pkg::ST_IDLE) begin
      xfer.load_word = spi_flash_pkg::flash_data_t'(cmd_opcode);
      xfer.load_len  = spi_flash_pkg::nbits_t'(spi_flash_pkg::OPCODE_BITS);
    end else begin
      case (nxt_phase)
        spi_flash_pkg::ST_ADDR: begin
          xfer.load_word = addr_q;
          xfer.load_len  = four_q ? spi_flash_pkg::nbits_t'(spi_flash_pkg::ADDR4_BITS) :
                                    spi_flash_pkg::nbits_t'(spi_flash_pkg::ADDR3_BITS);
        end
        spi_flash_pkg::ST_DUMMY: begin
          xfer.load_len = spi_flash_pkg::nbits_t'(dummy_q);
        end
        spi_flash_pkg::ST_DATA: begin
          xfer.load_word = wdata_q;
          xfer.load_len  = nbits_q;
          xfer.shift_out = (type_q == spi_flash_pkg::CT_WRITE);
        end
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or posedge arst_i) begin
    if (arst_i) begin
      state     <= spi_flash_pkg::ST_IDLE;
      ss        <= 1'b1;
      bit_cnt   <= '0;
      phase_len <= '0;
    end else begin
      if (xfer.load) begin
        bit_cnt   <= '0;
        phase_len <= xfer.load_len;
      end else if (xfer.sample_stb) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      case (state)
        spi_flash_pkg::ST_IDLE: begin
          if (start) begin
            state <= spi_flash_pkg::ST_OPCODE;
            ss    <= 1'b0;
          end
        end
        spi_flash_pkg::ST_END: state <= spi_flash_pkg::ST_IDLE;
        default: begin
          // phases change on the falling edge after their last bit.
          if (phase_adv) begin
            state <= nxt_phase;
            if (nxt_phase == spi_flash_pkg::ST_END) begin
              ss <= 1'b1;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state == spi_flash_pkg::ST_IDLE) && start) begin
      addr_q  <= address;
      wdata_q <= wdata;
      nbits_q <= cmd_nbits;
      dummy_q <= command[spi_flash_pkg::DUMMY_MSB:spi_flash_pkg::DUMMY_LSB];
      type_q  <= comm_type;
      four_q  <= four_byte_addr;
    end
  end

  a_done_single: assert property (
    @(posedge clk_i) disable iff (arst_i)
    done |=> !done
  ) else $error("done high for two cycles.");

endmodule

/* logic/spi_flash_master.sv */
`timescale 1ns/1ps

module spi_flash_master (
  input  logic                       clk_i,
  input  logic                       arst_i,
  input  logic                       soft_rst,
  input  logic                       reg_valid,
  input  spi_flash_pkg::flash_addr_t reg_address,
  input  spi_flash_pkg::cmd_word_t   reg_command,
  input  spi_flash_pkg::comm_type_e  reg_comm_type,
  input  logic                       reg_four_byte_addr,
  input  spi_flash_pkg::flash_data_t reg_wdata,
  output spi_flash_pkg::flash_data_t reg_rdata,
  output logic                       reg_done,
  input  logic                       cache_valid,
  input  spi_flash_pkg::cache_addr_t cache_addr,
  input  logic [3:0]                 cache_wstrb,
  output spi_flash_pkg::flash_data_t cache_rdata,
  output logic                       cache_ready,
  output logic                       sclk,
  output logic                       ss,
  output logic                       mosi,
  input  logic                       miso
);

  logic core_rst;
  logic start;
  logic busy;
  logic done;
  spi_flash_pkg::flash_addr_t sel_address;

  spi_xfer_if xfer ();

  flash_req_mux u_flash_req_mux (
    .clk_i       (clk_i),
    .arst_i      (arst_i),
    .soft_rst    (soft_rst),
    .core_rst    (core_rst),
    .cache_valid (cache_valid),
    .cache_addr  (cache_addr),
    .cache_wstrb (cache_wstrb),
    .cache_ready (cache_ready),
    .reg_valid   (reg_valid),
    .reg_address (reg_address),
    .start       (start),
    .sel_address (sel_address),
    .busy        (busy),
    .done        (done)
  );

  // cache reads reuse the command word and type from the register side.
  spi_flash_ctrl u_spi_flash_ctrl (
    .clk_i          (clk_i),
    .arst_i         (core_rst),
    .start          (start),
    .address        (sel_address),
    .command        (reg_command),
    .comm_type      (reg_comm_type),
    .four_byte_addr (reg_four_byte_addr),
    .wdata          (reg_wdata),
    .xfer           (xfer.ctrl),
    .ss             (ss),
    .busy           (busy),
    .done           (done)
  );

  sclk_gen u_sclk_gen (
    .clk_i  (clk_i),
    .arst_i (core_rst),
    .xfer   (xfer.clkgen),
    .sclk   (sclk)
  );

  spi_shifter u_spi_shifter (
    .clk_i  (clk_i),
    .arst_i (core_rst),
    .xfer   (xfer.shifter),
    .mosi   (mosi),
    .miso   (miso)
  );

  assign reg_done    = done;
  assign reg_rdata   = xfer.rx_word;
  assign cache_rdata = xfer.rx_word;

endmodule

/* bench/flash_model.sv */
`timescale 1ns/1ps

module flash_model (
  input  logic        sclk,
  input  logic        ss,
  input  logic        mosi,
  output logic        miso,
  input  logic [2:0]  addr_bytes,
  input  logic [3:0]  dummy_clks,
  output logic [31:0] read_key,
  output logic [7:0]  opcode,
  output logic [31:0] address,
  output logic [31:0] wr_word,
  output int          frame_bits
);

  // read data is the decoded address mixed with this key.
  localparam logic [31:0] PATTERN_KEY = 32'h5A3C_96E1;

  int addr_end;
  int hdr_bits;
  int data_idx;
  logic [31:0] pattern_word;

  assign read_key     = PATTERN_KEY;
  assign addr_end     = 8 + 8 * int'(addr_bytes);
  assign hdr_bits     = addr_end + int'(dummy_clks);
  assign pattern_word = address ^ PATTERN_KEY;

  initial begin
    miso = 1'b0;
  end

  // ss falls with sclk low, so a low sclk here marks a new frame.
  always @(posedge sclk or negedge ss) begin
    if (!sclk) begin
      frame_bits = 0;
      opcode     = '0;
      address    = '0;
      wr_word    = '0;
    end else if (!ss) begin
      if (frame_bits < 8) begin
        opcode = {opcode[6:0], mosi};
      end else if (frame_bits < addr_end) begin
        address = {address[30:0], mosi};
      end else if (frame_bits >= hdr_bits) begin
        wr_word = {wr_word[30:0], mosi};
      end
      frame_bits = frame_bits + 1;
    end
  end

  // mode 0 read data, driven on the falling edge ahead of its rising edge.
  always @(negedge sclk) begin
    if (!ss && frame_bits >= hdr_bits && frame_bits < hdr_bits + 32) begin
      data_idx = frame_bits - hdr_bits;
      miso <= pattern_word[31 - data_idx];
    end
  end

endmodule

/* bench/tb_spi_flash_master.sv */
`timescale 1ns/1ps

module tb_spi_flash_master;

  localparam int WAIT_CYCLES = 2000;
  localparam int EV_DONE = 0;
  localparam int EV_CACHE = 1;
  localparam int EV_MIDFRAME = 2;

  logic clk_i;
  logic arst_i;
  logic soft_rst;
  logic reg_valid;
  spi_flash_pkg::flash_addr_t reg_address;
  spi_flash_pkg::cmd_word_t reg_command;
  spi_flash_pkg::comm_type_e reg_comm_type;
  logic reg_four_byte_addr;
  spi_flash_pkg::flash_data_t reg_wdata;
  spi_flash_pkg::flash_data_t reg_rdata;
  logic reg_done;
  logic cache_valid;
  spi_flash_pkg::cache_addr_t cache_addr;
  logic [3:0] cache_wstrb;
  spi_flash_pkg::flash_data_t cache_rdata;
  logic cache_ready;
  logic sclk;
  logic ss;
  logic mosi;
  logic miso;

  logic [2:0] addr_bytes;
  logic [3:0] dummy_clks;
  logic [31:0] read_key;
  logic [7:0] m_opcode;
  logic [31:0] m_address;
  logic [31:0] m_wr_word;
  int m_frame_bits;

  // expected frame of the running transfer.
  logic [7:0] exp_opcode;
  logic [31:0] exp_address;
  logic [31:0] exp_rdata;
  logic [31:0] exp_wdata;
  int exp_frame_bits;
  logic chk_rdata;
  logic chk_wdata;
  logic quiet_chk;
  logic cache_ok;

  int chk_errors;
  int timeouts;
  integer seed;

  spi_flash_master u_spi_flash_master (.*);

  flash_model u_flash_model (
    .sclk       (sclk),
    .ss         (ss),
    .mosi       (mosi),
    .miso       (miso),
    .addr_bytes (addr_bytes),
    .dummy_clks (dummy_clks),
    .read_key   (read_key),
    .opcode     (m_opcode),
    .address    (m_address),
    .wr_word    (m_wr_word),
    .frame_bits (m_frame_bits)
  );

  always #5 clk_i = ~clk_i;

  function automatic void report_mismatch(input string name, input logic [31:0] expected,
                                          input logic [31:0] actual);
    chk_errors++;
    $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, expected, actual);
  endfunction

  // bus idle, checked after reset and after a soft reset.
  a_quiet: assert property (@(posedge clk_i) disable iff (arst_i)
    quiet_chk |-> {ss, sclk, reg_done, cache_ready} == 4'b1000)
    else report_mismatch("ss,sclk,reg_done,cache_ready", 32'h8,
                         {28'h0, $sampled(ss), $sampled(sclk), $sampled(reg_done),
                          $sampled(cache_ready)});
  a_ss_at_done: assert property (@(posedge clk_i) disable iff (arst_i) reg_done |-> ss)
    else report_mismatch("ss", 32'h1, {31'h0, $sampled(ss)});
  a_opcode: assert property (@(posedge clk_i) disable iff (arst_i)
    reg_done |-> m_opcode == exp_opcode)
    else report_mismatch("opcode", $sampled(exp_opcode), $sampled(m_opcode));
  a_frame_bits: assert property (@(posedge clk_i) disable iff (arst_i)
    reg_done |-> m_frame_bits == exp_frame_bits)
    else report_mismatch("frame bits", $sampled(exp_frame_bits), $sampled(m_frame_bits));
  a_address: assert property (@(posedge clk_i) disable iff (arst_i)
    reg_done |-> m_address == exp_address)
    else report_mismatch("address", $sampled(exp_address), $sampled(m_address));
  a_rdata: assert property (@(posedge clk_i) disable iff (arst_i)
    reg_done && chk_rdata |-> reg_rdata == exp_rdata)
    else report_mismatch("reg_rdata", $sampled(exp_rdata), $sampled(reg_rdata));
  a_wdata: assert property (@(posedge clk_i) disable iff (arst_i)
    reg_done && chk_wdata |-> m_wr_word == exp_wdata)
    else report_mismatch("write data", $sampled(exp_wdata), $sampled(m_wr_word));
  a_cache_rdata: assert property (@(posedge clk_i) disable iff (arst_i)
    cache_ready |-> cache_rdata == exp_rdata)
    else report_mismatch("cache_rdata", $sampled(exp_rdata), $sampled(cache_rdata));
  a_cache_owned: assert property (@(posedge clk_i) disable iff (arst_i)
    cache_ready |-> cache_ok)
    else report_mismatch("cache_ready", 32'h0, 32'h1);
  a_cache_pulse: assert property (@(posedge clk_i) disable iff (arst_i)
    cache_ready |=> !cache_ready)
    else report_mismatch("cache_ready", 32'h0, {31'h0, $sampled(cache_ready)});

  task automatic wait_event(input int sel, input string what);
    int cycles;
    logic seen;
    cycles = 0;
    seen = 1'b0;
    while (!seen && cycles < WAIT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
      case (sel)
        EV_CACHE: seen = cache_ready;
        EV_MIDFRAME: seen = !ss && (m_frame_bits >= 12);
        default: seen = reg_done;
      endcase
    end
    if (!seen) begin
      timeouts++;
      $display("TIMEOUT t=%0t %s did not finish in %0d cycles", $time, what, WAIT_CYCLES);
    end
  endtask

  // register fields, model layout and expected frame for one transfer.
  task automatic setup_transfer(input spi_flash_pkg::comm_type_e ct,
                                input logic [31:0] addr, input logic four,
                                input int ndata, input int dummy, input logic [31:0] wdata);
    int nb;
    int abits;
    int dm;
    logic [31:0] ea;
    logic [7:0] op;
    op = 8'($random(seed));
    nb = (ndata > 32) ? 32 : ndata;
    abits = 0;
    if (ct == spi_flash_pkg::CT_ADDR || ct == spi_flash_pkg::CT_READ ||
        ct == spi_flash_pkg::CT_WRITE) begin
      abits = four ? 32 : 24;
    end
    if (ct == spi_flash_pkg::CT_CMD || ct == spi_flash_pkg::CT_ADDR) begin
      nb = 0;
    end
    dm = (ct == spi_flash_pkg::CT_READ || ct == spi_flash_pkg::CT_READ_NOADDR) ? dummy : 0;
    ea = four ? addr : {8'h00, addr[23:0]};
    if (abits == 0) begin
      ea = '0;
    end
    exp_opcode         <= op;
    exp_address        <= ea;
    exp_frame_bits     <= 8 + abits + dm + nb;
    exp_rdata          <= (ea ^ read_key) >> (32 - nb);
    exp_wdata          <= wdata & ~(32'hFFFF_FFFF << nb);
    chk_rdata          <= (ct == spi_flash_pkg::CT_READ || ct == spi_flash_pkg::CT_READ_NOADDR);
    chk_wdata          <= (ct == spi_flash_pkg::CT_WRITE);
    addr_bytes         <= 3'(abits / 8);
    dummy_clks         <= 4'(dm);
    reg_command        <= {12'h000, 4'(dummy), 1'b0, 7'(ndata), op};
    reg_comm_type      <= ct;
    reg_four_byte_addr <= four;
    reg_wdata          <= wdata;
  endtask

  task automatic run_reg(input spi_flash_pkg::comm_type_e ct, input logic [31:0] addr,
                         input logic four, input int ndata, input int dummy,
                         input logic [31:0] wdata, input string what);
    @(posedge clk_i);
    setup_transfer(ct, addr, four, ndata, dummy, wdata);
    reg_address <= addr;
    reg_valid   <= 1'b1;
    quiet_chk   <= 1'b0;
    wait_event(EV_DONE, what);
    reg_valid <= 1'b0;
  endtask

  initial begin
    logic [31:0] raddr;
    logic [23:0] caddr;
    int nd;
    int dm;
    seed = 81499;
    chk_errors = 0;
    timeouts = 0;
    clk_i = 1'b0;
    arst_i = 1'b1;
    soft_rst = 1'b0;
    reg_valid = 1'b0;
    reg_address = '0;
    reg_command = '0;
    reg_comm_type = spi_flash_pkg::CT_CMD;
    reg_four_byte_addr = 1'b0;
    reg_wdata = '0;
    cache_valid = 1'b0;
    cache_addr = '0;
    cache_wstrb = '0;
    addr_bytes = '0;
    dummy_clks = '0;
    exp_opcode = '0;
    exp_address = '0;
    exp_rdata = '0;
    exp_wdata = '0;
    exp_frame_bits = 0;
    chk_rdata = 1'b0;
    chk_wdata = 1'b0;
    quiet_chk = 1'b0;
    cache_ok = 1'b0;
    repeat (5) @(posedge clk_i);
    arst_i    <= 1'b0;
    quiet_chk <= 1'b1;
    repeat (10) @(posedge clk_i);

    run_reg(spi_flash_pkg::CT_CMD, '0, 1'b0, 0, 0, '0, "command");

    // first read takes a full word, the second an oversized count.
    for (int i = 0; i < 6; i++) begin
      nd = (i == 0) ? 32 : ((i == 1) ? 45 : 1 + $unsigned($random(seed)) % 32);
      dm = 1 + $unsigned($random(seed)) % 15;
      run_reg(spi_flash_pkg::CT_READ, $random(seed), 1'b0, nd, dm, '0, "3-byte read");
    end
    run_reg(spi_flash_pkg::CT_READ, $random(seed), 1'b1, 16, 8, '0, "4-byte read");

    for (int i = 0; i < 3; i++) begin
      nd = (i == 0) ? 32 : 1 + $unsigned($random(seed)) % 32;
      run_reg(spi_flash_pkg::CT_WRITE, $random(seed), 1'b1, nd, 0, $random(seed), "write");
    end
    run_reg(spi_flash_pkg::CT_ADDR, $random(seed), 1'b0, 0, 0, '0, "erase");
    run_reg(spi_flash_pkg::CT_READ_NOADDR, $random(seed), 1'b0, 24, 2, '0, "read ID");

    // cache and register requests raised together.
    raddr = $random(seed);
    caddr = 24'($random(seed));
    @(posedge clk_i);
    setup_transfer(spi_flash_pkg::CT_READ, {8'h00, caddr}, 1'b0, 32, 8, '0);
    reg_address <= raddr;
    reg_valid   <= 1'b1;
    cache_addr  <= caddr;
    cache_wstrb <= 4'h0;
    cache_valid <= 1'b1;
    cache_ok    <= 1'b1;
    wait_event(EV_CACHE, "cache read");
    cache_valid <= 1'b0;
    cache_ok    <= 1'b0;
    setup_transfer(spi_flash_pkg::CT_READ, raddr, 1'b0, 32, 8, '0);
    wait_event(EV_DONE, "register read behind cache read");
    reg_valid <= 1'b0;

    // soft reset in the middle of a frame.
    @(posedge clk_i);
    setup_transfer(spi_flash_pkg::CT_READ, $random(seed), 1'b1, 32, 4, '0);
    reg_address <= $random(seed);
    reg_valid   <= 1'b1;
    wait_event(EV_MIDFRAME, "read before soft reset");
    soft_rst  <= 1'b1;
    reg_valid <= 1'b0;
    quiet_chk <= 1'b1;
    repeat (2) @(posedge clk_i);
    soft_rst <= 1'b0;
    repeat (40) @(posedge clk_i);

    // a cache write stays pending and is never served.
    cache_addr  <= 24'($random(seed));
    cache_wstrb <= 4'hF;
    cache_valid <= 1'b1;
    run_reg(spi_flash_pkg::CT_READ, $random(seed), 1'b0, 20, 6, '0, "read after soft reset");
    cache_valid <= 1'b0;
    repeat (5) @(posedge clk_i);

    $display("check errors: %0d, timeouts: %0d", chk_errors, timeouts);
    if (chk_errors == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* tb.f */
logic/spi_flash_pkg.sv
logic/spi_xfer_if.sv
logic/flash_req_mux.sv
logic/sclk_gen.sv
logic/spi_shifter.sv
logic/spi_flash_ctrl.sv
logic/spi_flash_master.sv
bench/flash_model.sv
bench/tb_spi_flash_master.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_spi_flash_master
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
